/* logic/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// master to slave, held until ack.
	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [ADDR_W-1:0] adr;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic              ack;
		logic [DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

/* logic/pubsub_pkg.sv */
`default_nettype none

package pubsub_pkg;

	localparam int BLK_W = 4;

	typedef logic [BLK_W-1:0] blk_t;

	typedef struct packed {
		logic                      valid;
		blk_t                      base;
		logic [bus_pkg::DATA_W-1:0] seed;
	} st_cmd_t;

	typedef struct packed {
		logic valid;
		blk_t base;
	} ld_cmd_t;

	typedef struct packed {
		logic                      valid;
		blk_t                      base;
		logic [bus_pkg::DATA_W-1:0] seed;
	} st_done_t;

	typedef struct packed {
		logic                      valid;
		blk_t                      base;
		logic [bus_pkg::DATA_W-1:0] checksum;
	} ld_result_t;

	// engine asks the manager for a block.
	typedef struct packed {
		logic req;
		blk_t base;
	} claim_t;

endpackage

`default_nettype wire

/* logic/pub_domain_man.sv */
`default_nettype none
`timescale 1ns/100ps

module pub_domain_man #(
	parameter int NUM_ENTRY = 4
) (
	input  logic               clock,
	input  logic               reset,
	input  pubsub_pkg::claim_t st_claim [2],
	input  pubsub_pkg::claim_t ld_claim [2],
	input  logic               st_end [2],
	input  logic               ld_end [2],
	output logic               st_grant [2],
	output logic               ld_grant [2]
);
	import pubsub_pkg::*;

	localparam int EW = (NUM_ENTRY > 1) ? $clog2(NUM_ENTRY) : 1;

	logic [NUM_ENTRY-1:0] valid;
	logic [NUM_ENTRY-1:0] stored;
	logic [NUM_ENTRY-1:0] busy;
	blk_t                 tab_base [NUM_ENTRY];
	logic [EW-1:0]        st_entry [2];
	logic [EW-1:0]        ld_entry [2];

	logic                 free_found;
	logic [EW-1:0]        free_idx;
	logic                 st_hit [2];
	logic [EW-1:0]        st_idx [2];
	logic [EW-1:0]        st_tgt [2];
	logic                 st_ok [2];
	logic                 ld_hit [2];
	logic [EW-1:0]        ld_idx [2];
	logic                 ld_ok [2];
	logic                 st_pick;
	logic                 st_pick_id;
	logic                 st_pick_miss;
	logic [EW-1:0]        st_pick_ent;
	logic                 ld_pick;
	logic                 ld_pick_id;
	logic [EW-1:0]        ld_pick_ent;

	// returns {hit, entry} for a base among the live entries.
	function automatic logic [EW:0] lookup(blk_t b);
		logic [EW:0] r;
		r = '0;
		for (int e = 0; e < NUM_ENTRY; e++) begin
			if (valid[e] && tab_base[e] == b) begin
				r = {1'b1, EW'(e)};
			end
		end
		return r;
	endfunction

	// ------------------------------------------------------------
	// claim evaluation.
	// ------------------------------------------------------------
	always_comb begin
		free_found = 1'b0;
		free_idx = '0;
		for (int e = NUM_ENTRY - 1; e >= 0; e--) begin
			if (!valid[e]) begin
				free_found = 1'b1;
				free_idx = EW'(e);
			end
		end
		for (int i = 0; i < 2; i++) begin
			{st_hit[i], st_idx[i]} = lookup(st_claim[i].base);
			{ld_hit[i], ld_idx[i]} = lookup(ld_claim[i].base);
			st_tgt[i] = st_hit[i] ? st_idx[i] : free_idx;
			// a store fills a fresh entry or an idle unstored one.
			st_ok[i] = st_claim[i].req && !st_grant[i] &&
				(st_hit[i] ? (!stored[st_idx[i]] && !busy[st_idx[i]]) : free_found);
			ld_ok[i] = ld_claim[i].req && !ld_grant[i] && ld_hit[i] &&
				stored[ld_idx[i]] && !busy[ld_idx[i]];
		end
		st_pick = st_ok[0] || st_ok[1];
		st_pick_id = !st_ok[0];
		st_pick_ent = st_tgt[st_pick_id];
		st_pick_miss = !st_hit[st_pick_id];
		ld_pick = ld_ok[0] || ld_ok[1];
		ld_pick_id = !ld_ok[0];
		ld_pick_ent = ld_idx[ld_pick_id];
	end

	// ------------------------------------------------------------
	// table flags and grants.
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
			stored <= '0;
			busy <= '0;
			for (int i = 0; i < 2; i++) begin
				st_grant[i] <= 1'b0;
				ld_grant[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < 2; i++) begin
				st_grant[i] <= st_pick && (st_pick_id == 1'(i));
				ld_grant[i] <= ld_pick && (ld_pick_id == 1'(i));
				if (st_end[i]) begin
					stored[st_entry[i]] <= 1'b1;
					busy[st_entry[i]] <= 1'b0;
				end
				if (ld_end[i]) begin
					valid[ld_entry[i]] <= 1'b0;
					stored[ld_entry[i]] <= 1'b0;
					busy[ld_entry[i]] <= 1'b0;
				end
			end
			if (st_pick) begin
				valid[st_pick_ent] <= 1'b1;
				busy[st_pick_ent] <= 1'b1;
			end
			if (ld_pick) begin
				busy[ld_pick_ent] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (st_pick) begin
			st_entry[st_pick_id] <= st_pick_ent;
			if (st_pick_miss) begin
				tab_base[st_pick_ent] <= st_claim[st_pick_id].base;
			end
		end
		if (ld_pick) begin
			ld_entry[ld_pick_id] <= ld_pick_ent;
		end
	end

	for (genvar g = 0; g < 2; g++) begin : g_chk
		a_st_end_busy: assert property (@(posedge clock) disable iff (reset)
			st_end[g] |-> busy[st_entry[g]]);
		a_ld_end_busy: assert property (@(posedge clock) disable iff (reset)
			ld_end[g] |-> busy[ld_entry[g]]);
		a_ld_grant_stored: assert property (@(posedge clock) disable iff (reset)
			ld_grant[g] |-> stored[ld_entry[g]]);
	end

endmodule

`default_nettype wire

/* logic/store_engine.sv */
`default_nettype none
`timescale 1ns/100ps

module store_engine #(
	parameter int BURST_LEN = 8
) (
	input  logic                 clock,
	input  logic                 reset,
	input  pubsub_pkg::st_cmd_t  cmd,
	output logic                 cmd_ready,
	output pubsub_pkg::claim_t   claim,
	input  logic                 grant,
	output logic                 done_end,
	output pubsub_pkg::st_done_t done,
	output bus_pkg::wb_req_t     wb_req,
	input  bus_pkg::wb_rsp_t     wb_rsp
);
	import bus_pkg::*;
	import pubsub_pkg::*;

	localparam int CW = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

	typedef enum logic [1:0] {S_IDLE, S_CLAIM, S_WRITE, S_FINISH} state_t;

	state_t            state;
	logic              cyc;
	logic              stb;
	logic [CW-1:0]     cnt;
	logic              last;
	blk_t              base;
	logic [DATA_W-1:0] seed;

	assign last = (cnt == CW'(BURST_LEN - 1));
	assign cmd_ready = (state == S_IDLE);
	assign done_end = (state == S_FINISH);
	assign claim = '{req: (state == S_CLAIM), base: base};
	assign done = '{valid: done_end, base: base, seed: seed};
	// word i of block b sits at b * BURST_LEN + i.
	assign wb_req = '{cyc: cyc, stb: stb, we: 1'b1,
		adr: ADDR_W'(int'(base) * BURST_LEN + int'(cnt)),
		dat: seed + DATA_W'(cnt)};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			cyc <= 1'b0;
			stb <= 1'b0;
			cnt <= '0;
		end else begin
			case (state)
				S_IDLE: if (cmd.valid) state <= S_CLAIM;
				S_CLAIM: if (grant) begin
					state <= S_WRITE;
					cyc <= 1'b1;
					stb <= 1'b1;
					cnt <= '0;
				end
				S_WRITE: if (stb && wb_rsp.ack) begin
					stb <= 1'b0;
					if (last) begin
						cyc <= 1'b0;
						state <= S_FINISH;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end else if (!stb) begin
					stb <= 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (cmd_ready && cmd.valid) begin
			base <= cmd.base;
			seed <= cmd.seed;
		end
	end

	a_stb_cyc: assert property (@(posedge clock) disable iff (reset)
		wb_req.stb |-> wb_req.cyc);

endmodule

`default_nettype wire

/* logic/load_engine.sv */
`default_nettype none
`timescale 1ns/100ps

module load_engine #(
	parameter int BURST_LEN = 8
) (
	input  logic                   clock,
	input  logic                   reset,
	input  pubsub_pkg::ld_cmd_t    cmd,
	output logic                   cmd_ready,
	output pubsub_pkg::claim_t     claim,
	input  logic                   grant,
	output logic                   done_end,
	output pubsub_pkg::ld_result_t result,
	output bus_pkg::wb_req_t       wb_req,
	input  bus_pkg::wb_rsp_t       wb_rsp
);
	import bus_pkg::*;
	import pubsub_pkg::*;

	localparam int CW = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

	typedef enum logic [1:0] {S_IDLE, S_CLAIM, S_READ, S_FINISH} state_t;

	state_t            state;
	logic              cyc;
	logic              stb;
	logic [CW-1:0]     cnt;
	logic              last;
	logic              take;
	blk_t              base;
	logic [DATA_W-1:0] sum;

	assign last = (cnt == CW'(BURST_LEN - 1));
	assign take = (state == S_READ) && stb && wb_rsp.ack;
	assign cmd_ready = (state == S_IDLE);
	assign done_end = (state == S_FINISH);
	assign claim = '{req: (state == S_CLAIM), base: base};
	assign result = '{valid: done_end, base: base, checksum: sum};
	assign wb_req = '{cyc: cyc, stb: stb, we: 1'b0,
		adr: ADDR_W'(int'(base) * BURST_LEN + int'(cnt)),
		dat: '0};

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			cyc <= 1'b0;
			stb <= 1'b0;
			cnt <= '0;
		end else begin
			case (state)
				S_IDLE: if (cmd.valid) state <= S_CLAIM;
				S_CLAIM: if (grant) begin
					state <= S_READ;
					cyc <= 1'b1;
					stb <= 1'b1;
					cnt <= '0;
				end
				S_READ: if (take) begin
					stb <= 1'b0;
					if (last) begin
						cyc <= 1'b0;
						state <= S_FINISH;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end else if (!stb) begin
					stb <= 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// wrapping sum of the burst.
	always_ff @(posedge clock) begin
		if (cmd_ready && cmd.valid) begin
			base <= cmd.base;
			sum <= '0;
		end else if (take) begin
			sum <= sum + wb_rsp.dat;
		end
	end

endmodule

`default_nettype wire

/* logic/bus_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

module bus_arbiter (
	input  logic             clock,
	input  logic             reset,
	input  bus_pkg::wb_req_t m_req [4],
	output bus_pkg::wb_rsp_t m_rsp [4],
	output bus_pkg::wb_req_t s_req,
	input  bus_pkg::wb_rsp_t s_rsp
);

	localparam int NUM_M = 4;

	logic       owned;
	logic [1:0] owner;
	logic [1:0] next_owner;
	logic       any_cyc;

	// search starts at the master after the last owner.
	always_comb begin
		next_owner = owner;
		any_cyc = 1'b0;
		for (int k = NUM_M; k >= 1; k--) begin
			if (m_req[2'(int'(owner) + k)].cyc) begin
				next_owner = 2'(int'(owner) + k);
				any_cyc = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			owned <= 1'b0;
			owner <= 2'(NUM_M - 1);
		end else if (owned) begin
			if (!m_req[owner].cyc) begin
				owned <= 1'b0;
			end
		end else if (any_cyc) begin
			owned <= 1'b1;
			owner <= next_owner;
		end
	end

	assign s_req = owned ? m_req[owner] : '0;

	for (genvar g = 0; g < NUM_M; g++) begin : g_rsp
		assign m_rsp[g] = '{ack: owned && (owner == 2'(g)) && s_rsp.ack, dat: s_rsp.dat};
	end

	a_owner_hold: assert property (@(posedge clock) disable iff (reset)
		owned && m_req[owner].cyc |=> owned && $stable(owner));

endmodule

`default_nettype wire

/* logic/shared_ram.sv */
`default_nettype none
`timescale 1ns/100ps

module shared_ram #(
	parameter int DEPTH = 128
) (
	input  logic             clock,
	input  logic             reset,
	input  bus_pkg::wb_req_t wb_req,
	output bus_pkg::wb_rsp_t wb_rsp
);
	import bus_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [DATA_W-1:0] mem [DEPTH];
	logic [DATA_W-1:0] rdata;
	logic [AW-1:0]     idx;
	logic              ack;
	logic              access;

	assign idx = AW'(wb_req.adr);
	// one ack per strobe.
	assign access = wb_req.cyc && wb_req.stb && !ack;
	assign wb_rsp = '{ack: ack, dat: rdata};

	always_ff @(posedge clock) begin
		if (reset) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge clock) begin
		if (access && wb_req.we) begin
			mem[idx] <= wb_req.dat;
		end
		rdata <= mem[idx];
	end

endmodule

`default_nettype wire

/* logic/pubsub_top.sv */
`default_nettype none
`timescale 1ns/100ps

module pubsub_top #(
	parameter int NUM_ENTRY = 4,
	parameter int BURST_LEN = 8
) (
	input  logic                   clock,
	input  logic                   reset,
	input  pubsub_pkg::st_cmd_t    st_cmd [2],
	output logic                   st_cmd_ready [2],
	input  pubsub_pkg::ld_cmd_t    ld_cmd [2],
	output logic                   ld_cmd_ready [2],
	output pubsub_pkg::st_done_t   st_done [2],
	output pubsub_pkg::ld_result_t ld_result [2]
);
	import bus_pkg::*;
	import pubsub_pkg::*;

	claim_t  st_claim [2];
	claim_t  ld_claim [2];
	logic    st_grant [2];
	logic    ld_grant [2];
	logic    st_end [2];
	logic    ld_end [2];
	wb_req_t m_req [4];
	wb_rsp_t m_rsp [4];
	wb_req_t s_req;
	wb_rsp_t s_rsp;

	// stores are masters 0 and 1, loads are masters 2 and 3.
	for (genvar i = 0; i < 2; i++) begin : g_eng
		store_engine #(.BURST_LEN(BURST_LEN)) u_store (
			.clock(clock), .reset(reset),
			.cmd(st_cmd[i]), .cmd_ready(st_cmd_ready[i]),
			.claim(st_claim[i]), .grant(st_grant[i]), .done_end(st_end[i]),
			.done(st_done[i]),
			.wb_req(m_req[i]), .wb_rsp(m_rsp[i])
		);
		load_engine #(.BURST_LEN(BURST_LEN)) u_load (
			.clock(clock), .reset(reset),
			.cmd(ld_cmd[i]), .cmd_ready(ld_cmd_ready[i]),
			.claim(ld_claim[i]), .grant(ld_grant[i]), .done_end(ld_end[i]),
			.result(ld_result[i]),
			.wb_req(m_req[i + 2]), .wb_rsp(m_rsp[i + 2])
		);
	end

	pub_domain_man #(.NUM_ENTRY(NUM_ENTRY)) u_man (
		.clock(clock), .reset(reset),
		.st_claim(st_claim), .ld_claim(ld_claim),
		.st_end(st_end), .ld_end(ld_end),
		.st_grant(st_grant), .ld_grant(ld_grant)
	);

	bus_arbiter u_arb (
		.clock(clock), .reset(reset),
		.m_req(m_req), .m_rsp(m_rsp),
		.s_req(s_req), .s_rsp(s_rsp)
	);

	shared_ram #(.DEPTH(16 * BURST_LEN)) u_ram (
		.clock(clock), .reset(reset),
		.wb_req(s_req), .wb_rsp(s_rsp)
	);

endmodule

`default_nettype wire

/* bench/tb_pubsub.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_pubsub;
	import bus_pkg::*;
	import pubsub_pkg::*;

	localparam int NUM_ENTRY = 4;
	localparam int BURST_LEN = 8;
	localparam int NUM_BLK = 16;
	localparam int RANDOM_CMDS = 60;
	// directed tests, random traffic and the final drain.
	localparam int NUM_CMDS = 18 + RANDOM_CMDS + NUM_ENTRY;

	logic       clock = 1'b0;
	logic       reset;
	st_cmd_t    st_cmd [2];
	logic       st_cmd_ready [2];
	ld_cmd_t    ld_cmd [2];
	logic       ld_cmd_ready [2];
	st_done_t   st_done [2];
	ld_result_t ld_result [2];

	integer seed = 32'h1e79a1bd;

	// commands sent by the stimulus against completions seen by the scoreboard.
	st_done_t          exp_done [2];
	blk_t              ld_base [2];
	int                st_sent [2];
	int                st_seen [2];
	int                ld_sent [2];
	int                ld_seen [2];
	int                st_count [NUM_BLK];
	int                ld_count [NUM_BLK];
	int                res_count [NUM_BLK];
	logic [DATA_W-1:0] seed_q [NUM_BLK][$];

	pubsub_top #(.NUM_ENTRY(NUM_ENTRY), .BURST_LEN(BURST_LEN)) i_pubsub_top (
		.clock(clock), .reset(reset),
		.st_cmd(st_cmd), .st_cmd_ready(st_cmd_ready),
		.ld_cmd(ld_cmd), .ld_cmd_ready(ld_cmd_ready),
		.st_done(st_done), .ld_result(ld_result)
	);

	always #5 clock = ~clock;

	// ------------------------------------------------------------
	// reference model and bookkeeping.
	// ------------------------------------------------------------
	function automatic logic [DATA_W-1:0] expected_checksum(input logic [DATA_W-1:0] s);
		logic [DATA_W-1:0] sum;
		sum = '0;
		for (int i = 0; i < BURST_LEN; i++) begin
			sum = sum + s + DATA_W'(i);
		end
		return sum;
	endfunction

	function automatic logic is_live(input blk_t b);
		return st_count[b] != res_count[b];
	endfunction

	function automatic int live_blocks();
		int n;
		n = 0;
		for (int b = 0; b < NUM_BLK; b++) begin
			if (is_live(blk_t'(b))) begin
				n++;
			end
		end
		return n;
	endfunction

	function automatic logic all_idle();
		logic idle;
		idle = 1'b1;
		for (int i = 0; i < 2; i++) begin
			if (st_sent[i] != st_seen[i] || ld_sent[i] != ld_seen[i]) begin
				idle = 1'b0;
			end
		end
		return idle;
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_done(input st_done_t got, input st_done_t want, input string name);
		if (got !== want) begin
			report_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, want));
		end
	endtask

	task automatic check_result(input ld_result_t got, input ld_result_t want,
			input string name);
		if (got !== want) begin
			report_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, want));
		end
	endtask

	task automatic check_idle();
		for (int i = 0; i < 2; i++) begin
			if (st_cmd_ready[i] !== 1'b1 || ld_cmd_ready[i] !== 1'b1) begin
				report_error($sformatf("command port pair %0d is not ready while idle", i));
			end
			if (st_done[i].valid !== 1'b0) begin
				report_error($sformatf("Mismatch st_done[%0d].valid: got 0x%h expected 0x0",
					i, st_done[i].valid));
			end
			if (ld_result[i].valid !== 1'b0) begin
				report_error($sformatf("Mismatch ld_result[%0d].valid: got 0x%h expected 0x0",
					i, ld_result[i].valid));
			end
		end
	endtask

	// ------------------------------------------------------------
	// command drivers, entered and left on a falling edge.
	// ------------------------------------------------------------
	task automatic send_store(input int eng, input blk_t b, input logic [DATA_W-1:0] s);
		while (st_cmd_ready[eng] !== 1'b1) begin
			@(negedge clock);
		end
		st_cmd[eng] = '{valid: 1'b1, base: b, seed: s};
		exp_done[eng] = '{valid: 1'b1, base: b, seed: s};
		st_sent[eng]++;
		st_count[b]++;
		@(negedge clock);
		st_cmd[eng] = '0;
	endtask

	task automatic send_load(input int eng, input blk_t b);
		while (ld_cmd_ready[eng] !== 1'b1) begin
			@(negedge clock);
		end
		ld_cmd[eng] = '{valid: 1'b1, base: b};
		ld_base[eng] = b;
		ld_sent[eng]++;
		ld_count[b]++;
		@(negedge clock);
		ld_cmd[eng] = '0;
	endtask

	task automatic wait_idle();
		while (!all_idle()) begin
			@(negedge clock);
		end
	endtask

	// loads every block still published, then expects empty queues.
	task automatic drain_loads();
		int eng;
		eng = 0;
		for (int b = 0; b < NUM_BLK; b++) begin
			if (is_live(blk_t'(b)) && ld_count[b] == res_count[b]) begin
				send_load(eng, blk_t'(b));
				eng = 1 - eng;
			end
		end
		wait_idle();
		for (int b = 0; b < NUM_BLK; b++) begin
			if (seed_q[b].size() != 0) begin
				report_error($sformatf("publish of block %0d was never consumed", b));
			end
		end
	endtask

	task automatic random_traffic();
		int   n;
		int   port;
		blk_t b;
		blk_t c;
		logic sent;
		n = 0;
		while (n < RANDOM_CMDS) begin
			port = $random(seed) & 3;
			b = blk_t'($random(seed));
			sent = 1'b0;
			if (port < 2) begin
				if (st_cmd_ready[port] && !is_live(b) && live_blocks() < NUM_ENTRY) begin
					send_store(port, b, $random(seed));
					sent = 1'b1;
				end
			end else if (ld_cmd_ready[port - 2]) begin
				// first published block at or above b with no load yet.
				for (int k = 0; k < NUM_BLK; k++) begin
					c = blk_t'(int'(b) + k);
					if (!sent && is_live(c) && ld_count[c] == res_count[c]) begin
						send_load(port - 2, c);
						sent = 1'b1;
					end
				end
			end
			if (sent) begin
				n++;
			end else begin
				@(negedge clock);
			end
		end
	endtask

	// ------------------------------------------------------------
	// scoreboard.
	// ------------------------------------------------------------
	always @(posedge clock) begin : scoreboard
		ld_result_t        want;
		logic [DATA_W-1:0] pub_seed;
		int                used;
		if (reset === 1'b0) begin
			for (int i = 0; i < 2; i++) begin
				if (st_done[i].valid === 1'b1) begin
					if (st_sent[i] == st_seen[i]) begin
						report_error($sformatf("store engine %0d finished without a command", i));
					end
					check_done(st_done[i], exp_done[i], $sformatf("st_done[%0d]", i));
					seed_q[st_done[i].base].push_back(st_done[i].seed);
					if (seed_q[st_done[i].base].size() > 1) begin
						report_error($sformatf("block %0d published again before it was consumed",
							st_done[i].base));
					end
					st_seen[i]++;
				end
			end
			for (int i = 0; i < 2; i++) begin
				if (ld_result[i].valid === 1'b1) begin
					if (ld_sent[i] == ld_seen[i]) begin
						report_error($sformatf("load engine %0d finished without a command", i));
					end
					if (seed_q[ld_base[i]].size() == 0) begin
						report_error($sformatf("load of block %0d finished before any publish",
							ld_base[i]));
					end
					pub_seed = seed_q[ld_base[i]].pop_front();
					want = '{valid: 1'b1, base: ld_base[i], checksum: expected_checksum(pub_seed)};
					check_result(ld_result[i], want, $sformatf("ld_result[%0d]", i));
					res_count[ld_base[i]]++;
					ld_seen[i]++;
				end
			end
			used = 0;
			for (int b = 0; b < NUM_BLK; b++) begin
				if (seed_q[b].size() != 0) begin
					used++;
				end
			end
			if (used > NUM_ENTRY) begin
				report_error("more blocks are published than the table has entries");
			end
		end
	end

	initial begin : watchdog
		repeat (NUM_CMDS * 400) @(posedge clock);
		report_error($sformatf("timeout after %0d cycles with work still pending",
			NUM_CMDS * 400));
	end

	initial begin : stimulus
		reset = 1'b1;
		for (int i = 0; i < 2; i++) begin
			st_cmd[i] = '0;
			ld_cmd[i] = '0;
		end
		repeat (16) @(negedge clock);
		reset = 1'b0;

		// quiet after reset.
		check_idle();
		repeat (20) begin
			@(negedge clock);
			check_idle();
		end

		send_store(0, 4'd3, $random(seed));
		wait_idle();
		send_load(0, 4'd3);
		wait_idle();

		// load waits for a block that is not yet stored.
		send_load(1, 4'd5);
		repeat (30) @(negedge clock);
		if (ld_sent[1] == ld_seen[1]) begin
			report_error("load of block 5 finished before its store");
		end
		send_store(1, 4'd5, $random(seed));
		wait_idle();

		// both stores on one block, consumed in publish order.
		send_store(0, 4'd7, $random(seed));
		send_store(1, 4'd7, $random(seed));
		send_load(0, 4'd7);
		send_load(1, 4'd7);
		wait_idle();

		// four blocks fill the table.
		for (int b = 8; b < 12; b++) begin
			send_store(b % 2, blk_t'(b), $random(seed));
		end
		wait_idle();
		send_store(0, 4'd12, $random(seed));
		repeat (40) @(negedge clock);
		if (st_sent[0] == st_seen[0]) begin
			report_error("store to a fifth block finished while the table was full");
		end
		send_load(0, 4'd9);
		wait_idle();
		drain_loads();

		random_traffic();
		drain_loads();
		check_idle();

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
logic/bus_pkg.sv
logic/pubsub_pkg.sv
logic/pub_domain_man.sv
logic/store_engine.sv
logic/load_engine.sv
logic/bus_arbiter.sv
logic/shared_ram.sv
logic/pubsub_top.sv
bench/tb_pubsub.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status follows the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f sim.f --top-module tb_pubsub -o tb_pubsub \
	&& ./obj_dir/tb_pubsub | tee /dev/stderr | grep -q "Verification passed" \
	&& echo "simulation run: PASS" \
	|| { echo "simulation run: FAIL"; exit 1; }
